//--- sim.f
source/sram_axi_pkg.sv
source/sram_bank.sv
source/sram_port_arbiter.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/sram_axi_slave.sv
verif/tb_sram_axi_slave.sv

//--- Makefile
TOP = tb_sram_axi_slave

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir

//--- verif/tb_sram_axi_slave.sv
`timescale 1ns/1ps

module tb_sram_axi_slave;
    import sram_axi_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int WINDOW_WORDS = 256;
    localparam int N_INIT       = 16;
    localparam int N_SINGLE     = 4;
    localparam int N_RAND       = 20;
    // Bursts issued by the whole sequence
    localparam int N_TXN = N_INIT + 4 * N_SINGLE + 2 * N_RAND + 9;

    typedef struct packed {
        axi_id_t id;
        resp_t   resp;
    } b_beat_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        resp_t     resp;
        logic      last;
    } r_beat_t;

    logic        clk = 1'b0;
    logic        rst;
    axi_aw_ar_t  aw;
    axi_aw_ar_t  ar;
    axi_w_t      w;
    logic        aw_valid;
    logic        ar_valid;
    logic        w_valid;
    logic        b_ready;
    logic        r_ready;
    logic        aw_ready;
    logic        ar_ready;
    logic        w_ready;
    logic        b_valid;
    logic        r_valid;
    logic        r_last;
    axi_id_t     b_id;
    axi_id_t     r_id;
    resp_t       b_resp;
    resp_t       r_resp;
    axi_data_t   r_data;

    axi_data_t   ref_mem [MEM_WORDS];
    b_beat_t     exp_b [$];
    r_beat_t     exp_r [$];
    b_beat_t     b_head;
    r_beat_t     r_head;
    logic [31:0] rng_state = 32'd70;
    logic [31:0] stall_bits;
    logic        stall_en = 1'b0;
    axi_addr_t   seq_addr;
    axi_len_t    seq_len;
    int          checks = 0;
    int          errors = 0;

    sram_axi_slave uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int random_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    function automatic axi_id_t random_id();
        logic [31:0] x;
        x = next_rand();
        return x[ID_W-1:0];
    endfunction

    function automatic axi_addr_t beat_addr(input axi_addr_t addr, input burst_t burst,
                                            input int beat);
        if (burst == BURST_FIXED) begin
            return addr;
        end
        return addr + axi_addr_t'(4 * beat);
    endfunction

    function automatic axi_data_t merge_bytes(input axi_data_t old, input axi_data_t data,
                                              input axi_strb_t strb);
        axi_data_t res;
        res = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Beyond 64 KiB reads as zero with SLVERR
    function automatic r_beat_t expected_word(input axi_addr_t addr);
        r_beat_t beat;
        beat = '0;
        if (addr >= axi_addr_t'(MEM_WORDS * 4)) begin
            beat.resp = RESP_SLVERR;
        end else begin
            beat.data = ref_mem[addr[15:2]];
            beat.resp = RESP_OKAY;
        end
        return beat;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                               input burst_t burst, input bit full_strb);
        axi_addr_t   a;
        logic [31:0] r;
        logic        err;
        b_beat_t     b;
        err = 1'b0;
        @(negedge clk);
        aw.id    = id;
        aw.addr  = addr;
        aw.len   = len;
        aw.burst = burst;
        aw_valid = 1'b1;
        do @(posedge clk); while (!aw_ready);
        @(negedge clk);
        aw_valid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            a       = beat_addr(addr, burst, i);
            r       = next_rand();
            w.data  = next_rand();
            w.strb  = full_strb ? 4'hF : r[3:0];
            w.last  = (i == int'(len));
            w_valid = 1'b1;
            if (a >= axi_addr_t'(MEM_WORDS * 4)) begin
                err = 1'b1;
            end else begin
                ref_mem[a[15:2]] = merge_bytes(ref_mem[a[15:2]], w.data, w.strb);
            end
            do @(posedge clk); while (!w_ready);
            @(negedge clk);
        end
        w_valid = 1'b0;
        b.id    = id;
        b.resp  = err ? RESP_SLVERR : RESP_OKAY;
        exp_b.push_back(b);
        do @(posedge clk); while (!(b_valid && b_ready));
    endtask

    task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                              input burst_t burst);
        r_beat_t beat;
        for (int i = 0; i <= int'(len); i++) begin
            beat      = expected_word(beat_addr(addr, burst, i));
            beat.id   = id;
            beat.last = (i == int'(len));
            exp_r.push_back(beat);
        end
        @(negedge clk);
        ar.id    = id;
        ar.addr  = addr;
        ar.len   = len;
        ar.burst = burst;
        ar_valid = 1'b1;
        do @(posedge clk); while (!ar_ready);
        @(negedge clk);
        ar_valid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            do @(posedge clk); while (!(r_valid && r_ready));
        end
    endtask

    // Compare every B and R handshake with the queued expectations
    always @(posedge clk) begin
        if (rst && b_valid && b_ready) begin
            if (exp_b.size() == 0) begin
                $display("Write response at %0t ns with no write outstanding", $time);
                errors++;
            end else begin
                b_head = exp_b.pop_front();
                checks++;
                if (b_id !== b_head.id) begin
                    report_mismatch("b_id", 32'(b_head.id), 32'(b_id));
                end
                if (b_resp !== b_head.resp) begin
                    report_mismatch("b_resp", 32'(b_head.resp), 32'(b_resp));
                end
            end
        end
        if (rst && r_valid && r_ready) begin
            if (exp_r.size() == 0) begin
                $display("Read data at %0t ns with no read outstanding", $time);
                errors++;
            end else begin
                r_head = exp_r.pop_front();
                checks++;
                if (r_id !== r_head.id) begin
                    report_mismatch("r_id", 32'(r_head.id), 32'(r_id));
                end
                if (r_data !== r_head.data) begin
                    report_mismatch("r_data", r_head.data, r_data);
                end
                if (r_resp !== r_head.resp) begin
                    report_mismatch("r_resp", 32'(r_head.resp), 32'(r_resp));
                end
                if (r_last !== r_head.last) begin
                    report_mismatch("r_last", 32'(r_head.last), 32'(r_last));
                end
            end
        end
    end

    // Ready stalls about one cycle in four when enabled
    initial begin
        r_ready = 1'b0;
        b_ready = 1'b0;
        forever begin
            @(negedge clk);
            stall_bits = next_rand();
            r_ready = !stall_en || (stall_bits[1:0] != 2'b00);
            b_ready = !stall_en || (stall_bits[3:2] != 2'b00);
        end
    end

    initial begin
        #(N_TXN * 16 * 8 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns", N_TXN * 16 * 8 * CLK_PERIOD);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst      = 1'b0;
        aw       = '0;
        ar       = '0;
        w        = '0;
        aw_valid = 1'b0;
        ar_valid = 1'b0;
        w_valid  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Known contents across the test window
        for (int i = 0; i < N_INIT; i++) begin
            write_burst(random_id(), axi_addr_t'(64 * i), 8'd15, BURST_INCR, 1'b1);
        end
        for (int i = 0; i < N_SINGLE; i++) begin
            seq_addr = axi_addr_t'(4 * random_below(WINDOW_WORDS));
            write_burst(random_id(), seq_addr, 8'd0, BURST_INCR, 1'b1);
            read_burst(random_id(), seq_addr, 8'd0, BURST_INCR);
        end
        // Partial strobes merge onto the old word
        for (int i = 0; i < N_SINGLE; i++) begin
            seq_addr = axi_addr_t'(4 * random_below(WINDOW_WORDS));
            write_burst(random_id(), seq_addr, 8'd0, BURST_INCR, 1'b0);
            read_burst(random_id(), seq_addr, 8'd0, BURST_INCR);
        end

        stall_en = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            seq_addr = axi_addr_t'(4 * random_below(WINDOW_WORDS - 16));
            seq_len  = axi_len_t'(random_below(16));
            write_burst(random_id(), seq_addr, seq_len, BURST_INCR, 1'b0);
            read_burst(random_id(), seq_addr, seq_len, BURST_INCR);
        end

        seq_addr = axi_addr_t'(4 * random_below(WINDOW_WORDS));
        write_burst(random_id(), seq_addr, 8'd5, BURST_FIXED, 1'b1);
        read_burst(random_id(), seq_addr, 8'd5, BURST_FIXED);

        // Out of range and then a burst across the top of memory
        write_burst(random_id(), 32'h0001_0000, 8'd3, BURST_INCR, 1'b1);
        read_burst(random_id(), 32'h0001_0000, 8'd3, BURST_INCR);
        write_burst(random_id(), 32'h0000_FFF8, 8'd3, BURST_INCR, 1'b1);
        read_burst(random_id(), 32'h0000_FFF8, 8'd3, BURST_INCR);
        read_burst(random_id(), 32'h0000_0000, 8'd15, BURST_INCR);

        // Both engines busy together on disjoint ranges
        fork
            write_burst(random_id(), axi_addr_t'(4 * random_below(64)), 8'd15, BURST_INCR, 1'b0);
            read_burst(random_id(), axi_addr_t'(512 + 4 * random_below(64)), 8'd15, BURST_INCR);
        join

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- source/sram_axi_slave.sv
`timescale 1ns/1ps

module sram_axi_slave (
    input  logic                      clk,
    input  logic                      rst,
    input  sram_axi_pkg::axi_aw_ar_t  aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  sram_axi_pkg::axi_w_t      w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output sram_axi_pkg::axi_id_t     b_id,
    output sram_axi_pkg::resp_t       b_resp,
    output logic                      b_valid,
    input  logic                      b_ready,
    input  sram_axi_pkg::axi_aw_ar_t  ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    output sram_axi_pkg::axi_id_t     r_id,
    output sram_axi_pkg::axi_data_t   r_data,
    output sram_axi_pkg::resp_t       r_resp,
    output logic                      r_last,
    output logic                      r_valid,
    input  logic                      r_ready
);
    import sram_axi_pkg::*;

    logic       wr_req;
    logic       wr_gnt;
    sram_req_t  wr_req_data;
    logic       rd_req;
    logic       rd_gnt;
    sram_req_t  rd_req_data;
    axi_data_t  rd_data;
    logic       mem_cs;
    axi_strb_t  mem_we;
    word_addr_t mem_addr;
    axi_data_t  mem_wdata;

    axi_write_engine u_write (
        .clk         (clk),
        .rst         (rst),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b_id        (b_id),
        .b_resp      (b_resp),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .wr_req      (wr_req),
        .wr_req_data (wr_req_data),
        .wr_gnt      (wr_gnt)
    );

    axi_read_engine u_read (
        .clk         (clk),
        .rst         (rst),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r_id        (r_id),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .r_last      (r_last),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .rd_req      (rd_req),
        .rd_req_data (rd_req_data),
        .rd_gnt      (rd_gnt),
        .rd_data     (rd_data)
    );

    // Single SRAM port shared by both engines
    sram_port_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .wr_req      (wr_req),
        .wr_req_data (wr_req_data),
        .wr_gnt      (wr_gnt),
        .rd_req      (rd_req),
        .rd_req_data (rd_req_data),
        .rd_gnt      (rd_gnt),
        .mem_cs      (mem_cs),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    sram_bank u_bank (
        .clk   (clk),
        .cs    (mem_cs),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (rd_data)
    );

endmodule

//--- source/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  sram_axi_pkg::axi_aw_ar_t  ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    output sram_axi_pkg::axi_id_t     r_id,
    output sram_axi_pkg::axi_data_t   r_data,
    output sram_axi_pkg::resp_t       r_resp,
    output logic                      r_last,
    output logic                      r_valid,
    input  logic                      r_ready,
    output logic                      rd_req,
    output sram_axi_pkg::sram_req_t   rd_req_data,
    input  logic                      rd_gnt,
    input  sram_axi_pkg::axi_data_t   rd_data
);
    import sram_axi_pkg::*;

    typedef struct packed {
        axi_data_t data;
        resp_t     resp;
        logic      last;
    } rd_beat_t;

    rd_state_t state;
    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;
    burst_t    burst_q;
    axi_len_t  issue_cnt;
    axi_len_t  ret_cnt;
    logic      issue_done;
    logic      pend_valid;
    logic      pend_oob;
    logic      pend_last;
    rd_beat_t  beat_q [2];
    rd_beat_t  push_beat;
    logic      wr_ptr;
    logic      rd_ptr;
    logic [1:0] beat_cnt;
    logic [1:0] occupancy;
    logic      beat_oob;
    logic      can_issue;
    logic      issue;
    logic      last_issue;
    logic      ar_hs;
    logic      pop;

    assign ar_ready = (state == RD_IDLE);
    assign ar_hs    = ar_valid & ar_ready;
    assign pop      = r_valid & r_ready;

    assign beat_oob   = (addr_q[ADDR_W-1:WORD_AW+2] != '0);
    assign last_issue = (issue_cnt == len_q);

    // Beats buffered or in flight, less the one leaving now
    assign occupancy = beat_cnt + {1'b0, pend_valid} - {1'b0, pop};
    assign can_issue = (state == RD_BURST) & ~issue_done & (occupancy < 2'd2);

    // Out-of-range beats skip the SRAM
    assign rd_req = can_issue & ~beat_oob;
    assign issue  = can_issue & (beat_oob | rd_gnt);

    always_comb begin
        rd_req_data.addr  = addr_q[WORD_AW+1:2];
        rd_req_data.mask  = '0;
        rd_req_data.wdata = '0;
        rd_req_data.write = 1'b0;
    end

    // SRAM word arrives the cycle after the grant
    always_comb begin
        push_beat.data = pend_oob ? '0 : rd_data;
        push_beat.resp = pend_oob ? RESP_SLVERR : RESP_OKAY;
        push_beat.last = pend_last;
    end

    assign r_valid = (beat_cnt != 2'd0);
    assign r_id    = id_q;
    assign r_data  = beat_q[rd_ptr].data;
    assign r_resp  = beat_q[rd_ptr].resp;
    assign r_last  = beat_q[rd_ptr].last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= RD_IDLE;
            issue_cnt  <= '0;
            ret_cnt    <= '0;
            issue_done <= 1'b0;
            pend_valid <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            beat_cnt   <= 2'd0;
        end else begin
            pend_valid <= issue;
            if (pend_valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            beat_cnt <= beat_cnt + {1'b0, pend_valid} - {1'b0, pop};
            case (state)
                RD_IDLE: begin
                    if (ar_hs) begin
                        state      <= RD_BURST;
                        issue_cnt  <= '0;
                        ret_cnt    <= '0;
                        issue_done <= 1'b0;
                    end
                end
                RD_BURST: begin
                    if (issue) begin
                        issue_cnt  <= issue_cnt + axi_len_t'(1);
                        issue_done <= last_issue;
                    end
                    if (pop) begin
                        ret_cnt <= ret_cnt + axi_len_t'(1);
                        if (ret_cnt == len_q) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            id_q    <= ar.id;
            addr_q  <= ar.addr;
            len_q   <= ar.len;
            burst_q <= (ar.burst == BURST_FIXED) ? BURST_FIXED : BURST_INCR;
        end else if (issue && burst_q == BURST_INCR) begin
            addr_q <= addr_q + axi_addr_t'(4);
        end
        if (issue) begin
            pend_oob  <= beat_oob;
            pend_last <= last_issue;
        end
        if (pend_valid) begin
            beat_q[wr_ptr] <= push_beat;
        end
    end

endmodule

//--- source/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  sram_axi_pkg::axi_aw_ar_t  aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  sram_axi_pkg::axi_w_t      w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output sram_axi_pkg::axi_id_t     b_id,
    output sram_axi_pkg::resp_t       b_resp,
    output logic                      b_valid,
    input  logic                      b_ready,
    output logic                      wr_req,
    output sram_axi_pkg::sram_req_t   wr_req_data,
    input  logic                      wr_gnt
);
    import sram_axi_pkg::*;

    wr_state_t state;
    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;
    burst_t    burst_q;
    axi_len_t  beat_cnt;
    logic      err_q;
    logic      beat_oob;
    logic      burst_end;
    logic      aw_hs;
    logic      w_hs;
    logic      b_hs;

    assign aw_ready = (state == WR_IDLE);
    assign b_valid  = (state == WR_RESP);

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;

    // Anything above the 64 KiB window is out of range
    assign beat_oob  = (addr_q[ADDR_W-1:WORD_AW+2] != '0);
    assign burst_end = w.last | (beat_cnt == len_q);

    // A W beat completes in the cycle the arbiter grants it
    assign wr_req  = (state == WR_DATA) & w_valid;
    assign w_ready = wr_gnt;

    always_comb begin
        wr_req_data.addr  = addr_q[WORD_AW+1:2];
        wr_req_data.mask  = beat_oob ? '0 : w.strb;
        wr_req_data.wdata = w.data;
        wr_req_data.write = 1'b1;
    end

    assign b_id   = id_q;
    assign b_resp = err_q ? RESP_SLVERR : RESP_OKAY;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_hs) begin
                        state    <= WR_DATA;
                        beat_cnt <= '0;
                        err_q    <= 1'b0;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + axi_len_t'(1);
                        // Sticky over the whole burst
                        err_q    <= err_q | beat_oob;
                        if (burst_end) begin
                            state <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_hs) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q    <= aw.id;
            addr_q  <= aw.addr;
            len_q   <= aw.len;
            // WRAP falls back to INCR
            burst_q <= (aw.burst == BURST_FIXED) ? BURST_FIXED : BURST_INCR;
        end else if (w_hs && burst_q == BURST_INCR) begin
            addr_q <= addr_q + axi_addr_t'(4);
        end
    end

endmodule

//--- source/sram_port_arbiter.sv
`timescale 1ns/1ps

module sram_port_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_req,
    input  sram_axi_pkg::sram_req_t   wr_req_data,
    output logic                      wr_gnt,
    input  logic                      rd_req,
    input  sram_axi_pkg::sram_req_t   rd_req_data,
    output logic                      rd_gnt,
    output logic                      mem_cs,
    output sram_axi_pkg::axi_strb_t   mem_we,
    output sram_axi_pkg::word_addr_t  mem_addr,
    output sram_axi_pkg::axi_data_t   mem_wdata
);
    import sram_axi_pkg::*;

    // High when the write side won the last grant
    logic      last_wr;
    sram_req_t sel;

    // On a tie the side that lost last time goes first
    assign wr_gnt = wr_req & (~rd_req | ~last_wr);
    assign rd_gnt = rd_req & (~wr_req | last_wr);

    assign sel = wr_gnt ? wr_req_data : rd_req_data;

    assign mem_cs    = wr_gnt | rd_gnt;
    assign mem_we    = (mem_cs & sel.write) ? sel.mask : '0;
    assign mem_addr  = sel.addr;
    assign mem_wdata = sel.wdata;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            last_wr <= 1'b0;
        end else if (wr_gnt) begin
            last_wr <= 1'b1;
        end else if (rd_gnt) begin
            last_wr <= 1'b0;
        end
    end

endmodule

//--- source/sram_bank.sv
`timescale 1ns/1ps

module sram_bank (
    input  logic                      clk,
    input  logic                      cs,
    input  sram_axi_pkg::axi_strb_t   we,
    input  sram_axi_pkg::word_addr_t  addr,
    input  sram_axi_pkg::axi_data_t   wdata,
    output sram_axi_pkg::axi_data_t   rdata
);
    import sram_axi_pkg::*;

    axi_data_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (cs) begin
            // Byte lanes written independently
            for (int i = 0; i < STRB_W; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            if (we == '0) begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- source/sram_axi_pkg.sv
package sram_axi_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = 4;
    localparam int ID_W      = 8;
    localparam int LEN_W     = 8;
    localparam int WORD_AW   = 14;
    localparam int MEM_WORDS = 16384;

    typedef logic [ADDR_W-1:0]  axi_addr_t;
    typedef logic [DATA_W-1:0]  axi_data_t;
    typedef logic [STRB_W-1:0]  axi_strb_t;
    typedef logic [ID_W-1:0]    axi_id_t;
    typedef logic [LEN_W-1:0]   axi_len_t;
    typedef logic [WORD_AW-1:0] word_addr_t;
    typedef logic [1:0]         resp_t;
    typedef logic [1:0]         burst_t;

    localparam resp_t  RESP_OKAY   = 2'b00;
    localparam resp_t  RESP_SLVERR = 2'b10;
    localparam burst_t BURST_FIXED = 2'b00;
    localparam burst_t BURST_INCR  = 2'b01;

    // Shared by AW and AR
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
        burst_t    burst;
    } axi_aw_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    // One word request toward the SRAM port
    typedef struct packed {
        word_addr_t addr;
        axi_strb_t  mask;
        axi_data_t  wdata;
        logic       write;
    } sram_req_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_t;

endpackage
